/* verilog/mips_pkg.sv */
package mips_pkg;

    localparam int REGF_W = 5;
    localparam int DATA_W = 32;

    typedef enum logic [1:0] {
        TYPE_R,
        TYPE_I,
        TYPE_J
    } ityp_t;

    typedef enum logic [4:0] {
        OPER_NONE = 5'd0,     // reserved words land here
        OPER_ALUS, OPER_ALUU,
        OPER_MFHI, OPER_MFLO, OPER_MTHI, OPER_MTLO,
        OPER_JR, OPER_J,
        OPER_BEQ, OPER_BNE, OPER_BGTZ, OPER_BLEZ, OPER_BLTZ, OPER_BGEZ,
        OPER_LB, OPER_LBU, OPER_LH, OPER_LHU, OPER_LW,
        OPER_SB, OPER_SH, OPER_SW,
        OPER_BREAK, OPER_SYSCALL,
        OPER_MTC0, OPER_MFC0, OPER_ERET
    } oper_t;

    typedef enum logic [3:0] {
        FUNC_AND = 4'd0,      // also the don't-care value
        FUNC_OR, FUNC_XOR, FUNC_NOR,
        FUNC_SLL, FUNC_SRL, FUNC_SRA,
        FUNC_ADD, FUNC_SUB, FUNC_SLT,
        FUNC_MUL, FUNC_DIV, FUNC_LUI
    } func_t;

    typedef enum logic [2:0] {
        TRAP_NONE,
        TRAP_RI,
        TRAP_SY,
        TRAP_BP,
        TRAP_ER
    } trap_t;

    typedef struct packed {
        logic [5:0]        op;
        logic [REGF_W-1:0] rs;
        logic [REGF_W-1:0] rt;
        logic [REGF_W-1:0] rd;
        logic [4:0]        shamt;
        logic [5:0]        funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]        op;
        logic [REGF_W-1:0] rs;
        logic [REGF_W-1:0] rt;
        logic [15:0]       imm;
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] target;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } inst_word_t;

    function automatic logic is_jump_branch(oper_t oper);
        return oper inside {OPER_JR, OPER_J, OPER_BEQ, OPER_BNE,
                            OPER_BGTZ, OPER_BLEZ, OPER_BLTZ, OPER_BGEZ};
    endfunction

endpackage

/* verilog/fetch_window.sv */
module fetch_window #(
    parameter int LANES = 4
) (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic                                 fetch_valid,
    input  logic [mips_pkg::DATA_W-1:0]          fetch_pc,
    input  logic [LANES-1:0]                     fetch_mask,
    input  mips_pkg::inst_word_t [LANES-1:0]     fetch_insts,
    output logic                                 win_valid,
    output logic [mips_pkg::DATA_W-1:0]          win_pc,
    output logic [LANES-1:0]                     win_mask,
    output mips_pkg::inst_word_t [LANES-1:0]     win_insts
);
    import mips_pkg::*;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            win_valid <= 1'b0;
        end else begin
            win_valid <= fetch_valid;   // one-cycle strobe follows fetch
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            win_pc   <= fetch_pc;
            win_mask <= fetch_mask;
            for (int k = 0; k < LANES; k++) begin
                // empty lane becomes sll $0,$0,0
                win_insts[k] <= fetch_mask[k] ? fetch_insts[k] : inst_word_t'('0);
            end
        end
    end

    // lanes fill from lane 0 with no holes
    a_mask_contiguous: assert property (
        @(posedge clk) disable iff (!arst_n)
        fetch_valid |-> ((fetch_mask & (fetch_mask + 1'b1)) == '0)
    ) else $error("fetch_mask %b not contiguous from lane 0", fetch_mask);

endmodule

/* verilog/decode.sv */
module decode (
    input  mips_pkg::inst_word_t         inst,
    output mips_pkg::ityp_t              ityp,
    output mips_pkg::oper_t              oper,
    output mips_pkg::func_t              func,
    output logic [mips_pkg::DATA_W-1:0]  imme,
    output logic [mips_pkg::REGF_W-1:0]  rs_regf,
    output logic [mips_pkg::REGF_W-1:0]  rt_regf,
    output logic [mips_pkg::REGF_W-1:0]  rd_regf,
    output logic                         sy,
    output logic                         bp,
    output logic                         ri,
    output logic                         er
);
    import mips_pkg::*;

    logic [9:0]        dec;     // {known, oper, func}
    logic              shift;
    logic              store;
    logic              jalr;
    logic              jal;
    logic              bal;
    logic [REGF_W-1:0] rd_base;

    always_comb begin
        dec = '0;
        case (inst.r.op)
            6'b000000: case (inst.r.funct)
                6'b100100: dec = {1'b1, OPER_ALUS, FUNC_AND};       // and
                6'b100101: dec = {1'b1, OPER_ALUS, FUNC_OR};        // or
                6'b100110: dec = {1'b1, OPER_ALUS, FUNC_XOR};       // xor
                6'b100111: dec = {1'b1, OPER_ALUS, FUNC_NOR};       // nor
                6'b000000, 6'b000100: dec = {1'b1, OPER_ALUS, FUNC_SLL}; // sll, sllv
                6'b000010, 6'b000110: dec = {1'b1, OPER_ALUS, FUNC_SRL}; // srl, srlv
                6'b000011, 6'b000111: dec = {1'b1, OPER_ALUS, FUNC_SRA}; // sra, srav
                6'b010000: dec = {1'b1, OPER_MFHI, FUNC_AND};
                6'b010010: dec = {1'b1, OPER_MFLO, FUNC_AND};
                6'b010001: dec = {1'b1, OPER_MTHI, FUNC_AND};
                6'b010011: dec = {1'b1, OPER_MTLO, FUNC_AND};
                6'b100000: dec = {1'b1, OPER_ALUS, FUNC_ADD};       // add
                6'b100010: dec = {1'b1, OPER_ALUS, FUNC_SUB};       // sub
                6'b101010: dec = {1'b1, OPER_ALUS, FUNC_SLT};       // slt
                6'b011000: dec = {1'b1, OPER_ALUS, FUNC_MUL};       // mult
                6'b011010: dec = {1'b1, OPER_ALUS, FUNC_DIV};       // div
                6'b100001: dec = {1'b1, OPER_ALUU, FUNC_ADD};       // addu
                6'b100011: dec = {1'b1, OPER_ALUU, FUNC_SUB};       // subu
                6'b101011: dec = {1'b1, OPER_ALUU, FUNC_SLT};       // sltu
                6'b011001: dec = {1'b1, OPER_ALUU, FUNC_MUL};       // multu
                6'b011011: dec = {1'b1, OPER_ALUU, FUNC_DIV};       // divu
                6'b001000, 6'b001001: dec = {1'b1, OPER_JR, FUNC_AND}; // jr, jalr
                6'b001101: dec = {1'b1, OPER_BREAK, FUNC_AND};
                6'b001100: dec = {1'b1, OPER_SYSCALL, FUNC_AND};
                default:   dec = '0;
            endcase
            6'b001100: dec = {1'b1, OPER_ALUU, FUNC_AND};           // andi
            6'b001101: dec = {1'b1, OPER_ALUU, FUNC_OR};            // ori
            6'b001110: dec = {1'b1, OPER_ALUU, FUNC_XOR};           // xori
            6'b001111: dec = {1'b1, OPER_ALUU, FUNC_LUI};           // lui
            6'b001000: dec = {1'b1, OPER_ALUS, FUNC_ADD};           // addi
            6'b001001: dec = {1'b1, OPER_ALUU, FUNC_ADD};           // addiu
            6'b001010: dec = {1'b1, OPER_ALUS, FUNC_SLT};           // slti
            6'b001011: dec = {1'b1, OPER_ALUU, FUNC_SLT};           // sltiu
            6'b000010, 6'b000011: dec = {1'b1, OPER_J, FUNC_AND};   // j, jal
            6'b000100: dec = {1'b1, OPER_BEQ, FUNC_AND};
            6'b000101: dec = {1'b1, OPER_BNE, FUNC_AND};
            6'b000111: dec = {1'b1, OPER_BGTZ, FUNC_AND};
            6'b000110: dec = {1'b1, OPER_BLEZ, FUNC_AND};
            6'b000001: case (inst.i.rt)                             // regimm
                5'b00000, 5'b10000: dec = {1'b1, OPER_BLTZ, FUNC_AND};
                5'b00001, 5'b10001: dec = {1'b1, OPER_BGEZ, FUNC_AND};
                default:            dec = '0;
            endcase
            6'b100000: dec = {1'b1, OPER_LB, FUNC_ADD};
            6'b100100: dec = {1'b1, OPER_LBU, FUNC_ADD};
            6'b100001: dec = {1'b1, OPER_LH, FUNC_ADD};
            6'b100101: dec = {1'b1, OPER_LHU, FUNC_ADD};
            6'b100011: dec = {1'b1, OPER_LW, FUNC_ADD};
            6'b101000: dec = {1'b1, OPER_SB, FUNC_ADD};
            6'b101001: dec = {1'b1, OPER_SH, FUNC_ADD};
            6'b101011: dec = {1'b1, OPER_SW, FUNC_ADD};
            6'b010000: case (inst.r.rs)                             // cop0
                5'b00100: dec = {1'b1, OPER_MTC0, FUNC_AND};
                5'b00000: dec = {1'b1, OPER_MFC0, FUNC_AND};
                5'b10000: dec = {1'b1, OPER_ERET, FUNC_AND};
                default:  dec = '0;
            endcase
            default: dec = '0;
        endcase
    end

    assign oper  = oper_t'(dec[8:4]);
    assign func  = func_t'(dec[3:0]);
    assign shift = func inside {FUNC_SLL, FUNC_SRL, FUNC_SRA};
    assign store = oper inside {OPER_SB, OPER_SH, OPER_SW};

    assign ityp = (inst.r.op[5] || inst.r.op[3] || inst.r.op[2] || inst.r.op == 6'b000001)
                ? TYPE_I
                : (shift && !inst.r.funct[2]) ? TYPE_I        // constant shifts only
                : (oper inside {OPER_J, OPER_BREAK, OPER_SYSCALL, OPER_ERET}) ? TYPE_J
                : TYPE_R;

    assign imme = (ityp == TYPE_I)
                ? (shift ? {27'h0, inst.r.shamt}
                  : (inst.i.op[5:2] == 4'b0011) ? {16'h0, inst.i.imm}   // logical ops
                  : {{16{inst.i.imm[15]}}, inst.i.imm})
                : (ityp == TYPE_J) ? {6'h0, inst.j.target}
                : '0;

    // cop0 moves carry no gpr source in rs
    assign rs_regf = (ityp == TYPE_J || oper inside {OPER_MTC0, OPER_MFC0}) ? '0 : inst.r.rs;
    assign rt_regf = (oper inside {OPER_BEQ, OPER_BNE} || shift || store) ? inst.r.rt
                   : (ityp != TYPE_R) ? '0
                   : inst.r.rt;
    assign rd_base = (is_jump_branch(oper) || store) ? '0
                   : shift ? inst.r.rd
                   : (ityp == TYPE_I) ? inst.i.rt                 // i-type target is rt
                   : (ityp == TYPE_J) ? '0
                   : inst.r.rd;

    assign jalr = inst.r.op == 6'b000000 && inst.r.funct == 6'b001001;
    assign jal  = inst.j.op == 6'b000011;
    assign bal  = inst.i.op == 6'b000001 && inst.i.rt[4];   // bltzal, bgezal

    assign rd_regf = jalr ? ((inst.r.rd == '0) ? REGF_W'(31) : inst.r.rd)
                   : (jal || bal) ? REGF_W'(31)
                   : rd_base;

    assign sy = oper == OPER_SYSCALL;
    assign bp = oper == OPER_BREAK;
    assign ri = ~dec[9];
    assign er = oper == OPER_ERET;

    always_comb begin
        a_one_flag: assert ($onehot0({sy, bp, ri, er}))
            else $error("more than one trap flag for %h", inst);
    end

endmodule

/* verilog/issue_check.sv */
module issue_check #(
    parameter  int LANES = 4,
    localparam int CNT_W = $clog2(LANES + 1)
) (
    input  logic                                        clk,
    input  logic                                        arst_n,
    input  logic                                        win_valid,
    input  logic [mips_pkg::DATA_W-1:0]                 win_pc,
    input  logic [LANES-1:0]                            win_mask,
    input  mips_pkg::ityp_t [LANES-1:0]                 lane_ityp,
    input  mips_pkg::oper_t [LANES-1:0]                 lane_oper,
    input  mips_pkg::func_t [LANES-1:0]                 lane_func,
    input  logic [LANES-1:0][mips_pkg::DATA_W-1:0]      lane_imme,
    input  logic [LANES-1:0][mips_pkg::REGF_W-1:0]      lane_rs,
    input  logic [LANES-1:0][mips_pkg::REGF_W-1:0]      lane_rt,
    input  logic [LANES-1:0][mips_pkg::REGF_W-1:0]      lane_rd,
    input  logic [LANES-1:0]                            lane_sy,
    input  logic [LANES-1:0]                            lane_bp,
    input  logic [LANES-1:0]                            lane_ri,
    input  logic [LANES-1:0]                            lane_er,
    output logic                                        out_valid,
    output logic [mips_pkg::DATA_W-1:0]                 out_pc,
    output logic [LANES-1:0]                            out_mask,
    output logic [CNT_W-1:0]                            issue_count,
    output logic                                        trap,
    output mips_pkg::trap_t                             trap_cause,
    output mips_pkg::ityp_t [LANES-1:0]                 out_ityp,
    output mips_pkg::oper_t [LANES-1:0]                 out_oper,
    output mips_pkg::func_t [LANES-1:0]                 out_func,
    output logic [LANES-1:0][mips_pkg::DATA_W-1:0]      out_imme,
    output logic [LANES-1:0][mips_pkg::REGF_W-1:0]      out_rs,
    output logic [LANES-1:0][mips_pkg::REGF_W-1:0]      out_rt,
    output logic [LANES-1:0][mips_pkg::REGF_W-1:0]      out_rd
);
    import mips_pkg::*;

    logic [LANES-1:0] flag;
    logic [LANES-1:0] ok;       // lane may issue if all before it did
    logic [CNT_W-1:0] count_d;
    logic             trap_d;
    trap_t            cause_d;

    assign flag = lane_ri | lane_sy | lane_bp | lane_er;

    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            ok[k] = win_mask[k] && !flag[k];
            for (int j = 0; j < k; j++) begin
                // raw hazard on an earlier nonzero destination
                if (lane_rd[j] != '0 && (lane_rd[j] == lane_rs[k] || lane_rd[j] == lane_rt[k]))
                    ok[k] = 1'b0;
                if (is_jump_branch(lane_oper[j]))
                    ok[k] = 1'b0;   // branch ends the group
            end
        end
    end

    always_comb begin
        logic stop;
        stop    = 1'b0;
        count_d = '0;
        trap_d  = 1'b0;
        cause_d = TRAP_NONE;
        for (int k = 0; k < LANES; k++) begin
            if (!stop) begin
                if (ok[k]) begin
                    count_d = count_d + 1'b1;
                end else begin
                    stop   = 1'b1;
                    trap_d = win_mask[k] && flag[k];
                    if (win_mask[k])
                        cause_d = lane_ri[k] ? TRAP_RI
                                : lane_sy[k] ? TRAP_SY
                                : lane_bp[k] ? TRAP_BP
                                : lane_er[k] ? TRAP_ER
                                : TRAP_NONE;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid   <= 1'b0;
            issue_count <= '0;
            trap        <= 1'b0;
            trap_cause  <= TRAP_NONE;
        end else begin
            out_valid <= win_valid;
            if (win_valid) begin
                issue_count <= count_d;
                trap        <= trap_d;
                trap_cause  <= cause_d;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (win_valid) begin
            out_pc   <= win_pc;
            out_mask <= win_mask;
            out_ityp <= lane_ityp;
            out_oper <= lane_oper;
            out_func <= lane_func;
            out_imme <= lane_imme;
            out_rs   <= lane_rs;
            out_rt   <= lane_rt;
            out_rd   <= lane_rd;
        end
    end

    a_count_in_mask: assert property (
        @(posedge clk) disable iff (!arst_n)
        out_valid |-> (issue_count <= $countones(out_mask))
    ) else $error("issue_count %0d beyond mask %b", issue_count, out_mask);

endmodule

/* verilog/decode_stage.sv */
module decode_stage #(
    parameter  int LANES = 4,
    localparam int CNT_W = $clog2(LANES + 1)
) (
    input  logic                                        clk,
    input  logic                                        arst_n,
    input  logic                                        fetch_valid,
    input  logic [mips_pkg::DATA_W-1:0]                 fetch_pc,
    input  logic [LANES-1:0]                            fetch_mask,
    input  mips_pkg::inst_word_t [LANES-1:0]            fetch_insts,
    output logic                                        out_valid,
    output logic [mips_pkg::DATA_W-1:0]                 out_pc,
    output logic [LANES-1:0]                            out_mask,
    output logic [CNT_W-1:0]                            issue_count,
    output logic                                        trap,
    output mips_pkg::trap_t                             trap_cause,
    output mips_pkg::ityp_t [LANES-1:0]                 out_ityp,
    output mips_pkg::oper_t [LANES-1:0]                 out_oper,
    output mips_pkg::func_t [LANES-1:0]                 out_func,
    output logic [LANES-1:0][mips_pkg::DATA_W-1:0]      out_imme,
    output logic [LANES-1:0][mips_pkg::REGF_W-1:0]      out_rs,
    output logic [LANES-1:0][mips_pkg::REGF_W-1:0]      out_rt,
    output logic [LANES-1:0][mips_pkg::REGF_W-1:0]      out_rd
);
    import mips_pkg::*;

    logic                  win_valid;
    logic [DATA_W-1:0]     win_pc;
    logic [LANES-1:0]      win_mask;
    inst_word_t [LANES-1:0] win_insts;

    wire ityp_t [LANES-1:0]              lane_ityp;
    wire oper_t [LANES-1:0]              lane_oper;
    wire func_t [LANES-1:0]              lane_func;
    wire logic [LANES-1:0][DATA_W-1:0]   lane_imme;
    wire logic [LANES-1:0][REGF_W-1:0]   lane_rs;
    wire logic [LANES-1:0][REGF_W-1:0]   lane_rt;
    wire logic [LANES-1:0][REGF_W-1:0]   lane_rd;
    wire logic [LANES-1:0]               lane_sy;
    wire logic [LANES-1:0]               lane_bp;
    wire logic [LANES-1:0]               lane_ri;
    wire logic [LANES-1:0]               lane_er;

    fetch_window #(.LANES(LANES)) fetch_window_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_mask  (fetch_mask),
        .fetch_insts (fetch_insts),
        .win_valid   (win_valid),
        .win_pc      (win_pc),
        .win_mask    (win_mask),
        .win_insts   (win_insts)
    );

    for (genvar k = 0; k < LANES; k++) begin : g_lane
        decode decode_i (
            .inst    (win_insts[k]),
            .ityp    (lane_ityp[k]),
            .oper    (lane_oper[k]),
            .func    (lane_func[k]),
            .imme    (lane_imme[k]),
            .rs_regf (lane_rs[k]),
            .rt_regf (lane_rt[k]),
            .rd_regf (lane_rd[k]),
            .sy      (lane_sy[k]),
            .bp      (lane_bp[k]),
            .ri      (lane_ri[k]),
            .er      (lane_er[k])
        );
    end

    issue_check #(.LANES(LANES)) issue_check_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .win_valid   (win_valid),
        .win_pc      (win_pc),
        .win_mask    (win_mask),
        .lane_ityp   (lane_ityp),
        .lane_oper   (lane_oper),
        .lane_func   (lane_func),
        .lane_imme   (lane_imme),
        .lane_rs     (lane_rs),
        .lane_rt     (lane_rt),
        .lane_rd     (lane_rd),
        .lane_sy     (lane_sy),
        .lane_bp     (lane_bp),
        .lane_ri     (lane_ri),
        .lane_er     (lane_er),
        .out_valid   (out_valid),
        .out_pc      (out_pc),
        .out_mask    (out_mask),
        .issue_count (issue_count),
        .trap        (trap),
        .trap_cause  (trap_cause),
        .out_ityp    (out_ityp),
        .out_oper    (out_oper),
        .out_func    (out_func),
        .out_imme    (out_imme),
        .out_rs      (out_rs),
        .out_rt      (out_rt),
        .out_rd      (out_rd)
    );

endmodule

/* test/decode_model.svh */
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

localparam int N_ENC = 60;    // encodings 57..59 are reserved

typedef struct packed {
    inst_word_t  w;
    oper_t       oper;
    func_t       func;
    ityp_t       ityp;
    logic [31:0] imme;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    trap_t       cause;
} exp_t;

typedef struct packed {
    logic [31:0]     stamp;
    logic [31:0]     pc;
    logic [3:0]      mask;
    logic [2:0]      count;
    logic            trap;
    trap_t           cause;
    exp_t [3:0]      lane;
} grp_t;

localparam logic [5:0] ALU_FUNCT [14] = '{6'h24, 6'h25, 6'h26, 6'h27, 6'h20, 6'h22, 6'h2a,
                                          6'h18, 6'h1a, 6'h21, 6'h23, 6'h2b, 6'h19, 6'h1b};
localparam func_t ALU_FUNC [9] = '{FUNC_AND, FUNC_OR, FUNC_XOR, FUNC_NOR, FUNC_ADD,
                                   FUNC_SUB, FUNC_SLT, FUNC_MUL, FUNC_DIV};
localparam logic [5:0] SHIFT_FUNCT [6] = '{6'h04, 6'h06, 6'h07, 6'h00, 6'h02, 6'h03};
localparam func_t SHIFT_FUNC [3] = '{FUNC_SLL, FUNC_SRL, FUNC_SRA};
localparam logic [5:0] HILO_FUNCT [4] = '{6'h10, 6'h12, 6'h11, 6'h13};
localparam oper_t HILO_OPER [4] = '{OPER_MFHI, OPER_MFLO, OPER_MTHI, OPER_MTLO};
localparam logic [5:0] IMM_OP [8] = '{6'h0c, 6'h0d, 6'h0e, 6'h0f, 6'h08, 6'h09, 6'h0a, 6'h0b};
localparam func_t IMM_FUNC [8] = '{FUNC_AND, FUNC_OR, FUNC_XOR, FUNC_LUI,
                                   FUNC_ADD, FUNC_ADD, FUNC_SLT, FUNC_SLT};
localparam logic [5:0] BR_OP [4] = '{6'h04, 6'h05, 6'h07, 6'h06};
localparam oper_t BR_OPER [4] = '{OPER_BEQ, OPER_BNE, OPER_BGTZ, OPER_BLEZ};
localparam logic [5:0] MEM_OP [8] = '{6'h20, 6'h24, 6'h21, 6'h25, 6'h23, 6'h28, 6'h29, 6'h2b};
localparam oper_t MEM_OPER [8] = '{OPER_LB, OPER_LBU, OPER_LH, OPER_LHU, OPER_LW,
                                   OPER_SB, OPER_SH, OPER_SW};

function automatic exp_t make_inst(int idx, logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                   logic [4:0] sh, logic [15:0] imm);
    exp_t        e;
    logic [31:0] w;
    logic        it;
    logic        zext;
    logic        jt;
    w = {6'h00, rs, rt, rd, sh, 6'h00};
    it = 1'b0;
    zext = 1'b0;
    jt = 1'b0;
    e.oper = OPER_NONE;
    e.func = FUNC_AND;
    e.ityp = TYPE_R;
    e.imme = '0;
    e.rs = rs;
    e.rt = rt;
    e.rd = rd;
    e.cause = TRAP_NONE;
    case (idx) inside
        [0:13]: begin
            w[5:0] = ALU_FUNCT[idx];
            e.oper = (idx < 9) ? OPER_ALUS : OPER_ALUU;
            e.func = ALU_FUNC[(idx < 9) ? idx : idx - 5];
        end
        [14:19]: begin
            w[5:0] = SHIFT_FUNCT[idx - 14];
            e.oper = OPER_ALUS;
            e.func = SHIFT_FUNC[(idx - 14) % 3];
            if (idx >= 17) begin
                e.ityp = TYPE_I;    // constant shift takes shamt as immediate
                e.imme = {27'h0, sh};
            end
        end
        [20:23]: begin
            w[5:0] = HILO_FUNCT[idx - 20];
            e.oper = HILO_OPER[idx - 20];
        end
        [24:25]: begin
            w[5:0] = (idx == 24) ? 6'h08 : 6'h09;
            e.oper = OPER_JR;
            if (idx == 24)
                e.rd = 5'd0;
            else if (rd == 5'd0)
                e.rd = 5'd31;       // jalr with rd 0 links r31
        end
        [26:27]: begin
            w[5:0] = (idx == 26) ? 6'h0d : 6'h0c;
            e.oper = (idx == 26) ? OPER_BREAK : OPER_SYSCALL;
            e.cause = (idx == 26) ? TRAP_BP : TRAP_SY;
            jt = 1'b1;
        end
        [28:35]: begin
            w = {IMM_OP[idx - 28], rs, rt, imm};
            e.oper = (idx == 32 || idx == 34) ? OPER_ALUS : OPER_ALUU;
            e.func = IMM_FUNC[idx - 28];
            e.rt = 5'd0;
            e.rd = rt;
            it = 1'b1;
            zext = idx <= 31;    // logical ops and lui
        end
        [36:37]: begin
            w = {(idx == 36) ? 6'h02 : 6'h03, rs, rt, imm};
            e.oper = OPER_J;
            jt = 1'b1;
        end
        [38:41]: begin
            w = {BR_OP[idx - 38], rs, rt, imm};
            e.oper = BR_OPER[idx - 38];
            e.rd = 5'd0;
            if (idx >= 40)
                e.rt = 5'd0;
            it = 1'b1;
        end
        [42:45]: begin
            w = {6'h01, rs, idx >= 44, 3'b000, idx[0], imm};
            e.oper = idx[0] ? OPER_BGEZ : OPER_BLTZ;
            e.rt = 5'd0;
            e.rd = (idx >= 44) ? 5'd31 : 5'd0;   // and-link forms
            it = 1'b1;
        end
        [46:53]: begin
            w = {MEM_OP[idx - 46], rs, rt, imm};
            e.oper = MEM_OPER[idx - 46];
            e.func = FUNC_ADD;
            it = 1'b1;
            if (idx <= 50) begin
                e.rt = 5'd0;
                e.rd = rt;
            end else begin
                e.rd = 5'd0;
            end
        end
        [54:55]: begin
            w[31:21] = {6'h10, (idx == 54) ? 5'h04 : 5'h00};
            w[10:0] = '0;
            e.oper = (idx == 54) ? OPER_MTC0 : OPER_MFC0;
            e.rs = 5'd0;
        end
        56: begin
            w = {6'h10, 1'b1, 19'h0, 6'h18};
            e.oper = OPER_ERET;
            e.cause = TRAP_ER;
            jt = 1'b1;
        end
        57: begin
            w[31:26] = 6'h3f;
            e.cause = TRAP_RI;
        end
        58: begin
            w[5:0] = 6'h3f;
            e.cause = TRAP_RI;
        end
        default: begin
            w = {6'h01, rs, 5'b00010, imm};   // regimm with unused rt code
            e.cause = TRAP_RI;
        end
    endcase
    if (it) begin
        e.ityp = TYPE_I;
        e.imme = zext ? {16'h0, imm} : {{16{imm[15]}}, imm};
    end
    if (jt) begin
        e.ityp = TYPE_J;
        e.imme = {6'h0, w[25:0]};
        e.rs = 5'd0;
        e.rt = 5'd0;
        e.rd = (idx == 37) ? 5'd31 : 5'd0;   // jal
    end
    e.w = inst_word_t'(w);
    return e;
endfunction

function automatic logic ends_group(oper_t oper);
    return oper inside {OPER_JR, OPER_J, OPER_BEQ, OPER_BNE,
                        OPER_BGTZ, OPER_BLEZ, OPER_BLTZ, OPER_BGEZ};
endfunction

function automatic grp_t predict_issue(grp_t g);
    logic stop;
    logic ok;
    stop = 1'b0;
    g.count = '0;
    g.trap = 1'b0;
    g.cause = TRAP_NONE;
    for (int k = 0; k < 4; k++) begin
        ok = g.mask[k] && g.lane[k].cause == TRAP_NONE;
        for (int j = 0; j < k; j++) begin
            if (g.lane[j].rd != 5'd0
                && (g.lane[j].rd == g.lane[k].rs || g.lane[j].rd == g.lane[k].rt))
                ok = 1'b0;
            if (ends_group(g.lane[j].oper))
                ok = 1'b0;
        end
        if (!stop && ok) begin
            g.count = g.count + 3'd1;
        end else if (!stop) begin
            stop = 1'b1;
            if (g.mask[k] && g.lane[k].cause != TRAP_NONE) begin
                g.trap = 1'b1;
                g.cause = g.lane[k].cause;
            end
        end
    end
    return g;
endfunction

`endif

/* test/tb_decode_stage.sv */
module tb_decode_stage;
    timeunit 1ns;
    timeprecision 1ps;

    import mips_pkg::*;

    `include "decode_model.svh"

    localparam int LANES = 4;

    logic                   clk;
    logic                   arst_n;
    logic                   fetch_valid;
    logic [31:0]            fetch_pc;
    logic [3:0]             fetch_mask;
    inst_word_t [3:0]       fetch_insts;
    logic                   out_valid;
    logic [31:0]            out_pc;
    logic [3:0]             out_mask;
    logic [2:0]             issue_count;
    logic                   trap;
    trap_t                  trap_cause;
    ityp_t [3:0]            out_ityp;
    oper_t [3:0]            out_oper;
    func_t [3:0]            out_func;
    logic [3:0][31:0]       out_imme;
    logic [3:0][4:0]        out_rs;
    logic [3:0][4:0]        out_rt;
    logic [3:0][4:0]        out_rd;

    grp_t        q[$];     // groups in flight
    int          errors = 0;
    int          tests = 0;
    int          bad_tests = 0;
    logic [31:0] cyc = '0;

    decode_stage #(.LANES(LANES)) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 32'd1;

    task automatic check(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_group(grp_t g);
        check("out_pc", 64'(out_pc), 64'(g.pc));
        check("out_mask", 64'(out_mask), 64'(g.mask));
        check("issue_count", 64'(issue_count), 64'(g.count));
        check("trap", 64'(trap), 64'(g.trap));
        check("trap_cause", 64'(trap_cause), 64'(g.cause));
        check("out_valid cycle", 64'(cyc), 64'(g.stamp + 32'd2));
        for (int k = 0; k < 4; k++) begin
            check($sformatf("out_oper[%0d]", k), 64'(out_oper[k]), 64'(g.lane[k].oper));
            if (g.lane[k].oper != OPER_NONE) begin
                check($sformatf("out_ityp[%0d]", k), 64'(out_ityp[k]), 64'(g.lane[k].ityp));
                check($sformatf("out_func[%0d]", k), 64'(out_func[k]), 64'(g.lane[k].func));
                check($sformatf("out_imme[%0d]", k), 64'(out_imme[k]), 64'(g.lane[k].imme));
                check($sformatf("out_rs[%0d]", k), 64'(out_rs[k]), 64'(g.lane[k].rs));
                check($sformatf("out_rt[%0d]", k), 64'(out_rt[k]), 64'(g.lane[k].rt));
                check($sformatf("out_rd[%0d]", k), 64'(out_rd[k]), 64'(g.lane[k].rd));
            end
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (arst_n && out_valid) begin
            if (q.size() == 0) begin
                $display("output group at pc %h arrived with nothing expected", out_pc);
                errors++;
            end else begin
                compare_group(q.pop_front());
            end
        end
    end

    function automatic int plain_idx();
        int i;
        i = int'($urandom % 54);
        return (i >= 26) ? i + 2 : i;   // skip break and syscall
    endfunction

    task automatic send_group(logic [3:0] mask, int idx[4]);
        grp_t             g;
        inst_word_t [3:0] words;
        g.pc = $urandom & 32'hffff_fffc;
        g.mask = mask;
        for (int k = 0; k < 4; k++) begin
            if (mask[k]) begin
                g.lane[k] = make_inst(idx[k], 5'($urandom % 6), 5'($urandom % 6),
                                      5'($urandom % 6), 5'($urandom), 16'($urandom));
                words[k] = g.lane[k].w;
            end else begin
                g.lane[k] = make_inst(17, '0, '0, '0, '0, '0);   // empty lane reads as nop
                words[k] = inst_word_t'($urandom);
            end
        end
        g = predict_issue(g);
        @(posedge clk);
        g.stamp = cyc + 32'd1;   // index of this edge
        fetch_valid <= 1'b1;
        fetch_pc <= g.pc;
        fetch_mask <= mask;
        fetch_insts <= words;
        q.push_back(g);
    endtask

    task automatic wait_drain(string name);
        int t;
        t = 0;
        @(posedge clk);
        fetch_valid <= 1'b0;
        while (q.size() != 0 && t < 50) begin
            @(posedge clk);
            t++;
        end
        if (q.size() != 0) begin
            $display("%s: timed out waiting for out_valid, %0d groups missing", name, q.size());
            errors++;
            q.delete();
        end
    endtask

    task automatic end_test(string name, int base);
        tests++;
        if (errors == base) begin
            $display("test %s: ok", name);
        end else begin
            bad_tests++;
            $display("test %s: %0d mismatches", name, errors - base);
        end
    endtask

    initial begin
        int base;
        int idx[4];
        int trap_idx[6];
        trap_idx = '{26, 27, 56, 57, 58, 59};
        void'($urandom(13));
        arst_n = 1'b0;
        fetch_valid = 1'b0;
        fetch_pc = '0;
        fetch_mask = '0;
        fetch_insts = '0;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;

        base = errors;
        repeat (10) begin
            @(negedge clk);
            check("out_valid", 64'(out_valid), 64'd0);
            check("trap", 64'(trap), 64'd0);
            check("issue_count", 64'(issue_count), 64'd0);
        end
        end_test("idle after reset", base);

        base = errors;
        for (int r = 0; r < 3; r++) begin
            for (int i = 0; i < N_ENC; i++) begin
                idx = '{i, 0, 0, 0};
                send_group(4'b0001, idx);
                wait_drain("single lane decode");
            end
        end
        end_test("single lane decode", base);

        base = errors;
        repeat (300) begin
            foreach (idx[k]) idx[k] = plain_idx();
            send_group(4'b1111 >> ($urandom % 4), idx);
        end
        wait_drain("random issue groups");
        end_test("random issue groups", base);

        base = errors;
        repeat (200) begin
            foreach (idx[k]) idx[k] = plain_idx();
            idx[$urandom % 4] = trap_idx[$urandom % 6];
            send_group(4'b1111, idx);
            wait_drain("trap words");
        end
        end_test("trap words", base);

        base = errors;
        for (int n = 0; n < 8; n++) begin
            foreach (idx[k]) idx[k] = int'($urandom % N_ENC);
            send_group(4'b1111, idx);   // back to back strobes
        end
        wait_drain("back to back groups");
        end_test("back to back groups", base);

        $display("%0d tests run, %0d with mismatches, %0d mismatches in all",
                 tests, bad_tests, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* decode_stage.f */
+incdir+test
verilog/mips_pkg.sv
verilog/fetch_window.sv
verilog/decode.sv
verilog/issue_check.sv
verilog/decode_stage.sv
test/tb_decode_stage.sv

/* Makefile */
BIN  = obj_dir/Vtb_decode_stage
SRCS = $(wildcard verilog/*.sv) test/tb_decode_stage.sv test/decode_model.svh

.PHONY: all run clean

all: run

$(BIN): decode_stage.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module tb_decode_stage \
		-f decode_stage.f -o Vtb_decode_stage

run: $(BIN)
	@out=$$(./$(BIN)); echo "$$out"; echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf obj_dir
